// ==== sim/mult_trace.txt ====
# name op sign subword_hi imm is_clpx clpx_img clpx_shift a b c expected
# op and sign are decimal, a b c expected are hex
mac_basic    0 0 0 0 0 0 0 00000003 00000005 00000010 0000001F
mac_wrap     0 0 0 0 0 0 0 FFFFFFFF 00000002 00000001 FFFFFFFF
msu_basic    1 0 0 0 0 0 0 00000004 00000006 00000064 0000004C
msu_neg      1 0 0 0 0 0 0 00001000 00002000 00000000 FE000000
muli_lo_ss   2 3 0 0 0 0 0 0000FFFE 00000003 00000005 FFFFFFFF
muli_lo_rep  2 3 0 0 0 0 0 0000FFFE 00000003 00000005 FFFFFFFF
muli_hi_uu   2 0 1 4 0 0 0 00300000 00020000 00000004 00000006
muli_hi_su   2 1 1 2 0 0 0 FFFF0000 00070000 00000000 FFFFFFFE
mulir_lo     3 3 0 3 0 0 0 00000005 00000003 00000000 00000002
mulir_rep    3 3 0 3 0 0 0 00000005 00000003 00000000 00000002
mulir_neg    3 3 1 1 0 0 0 FFFD0000 00050000 00000000 FFFFFFF9
mulh_ss_neg  4 3 0 0 0 0 0 FFFFFFFF 00000005 00000000 FFFFFFFF
mulh_ss_pos  4 3 0 0 0 0 0 12345678 00010000 00000000 00001234
mulh_uu      4 0 0 0 0 0 0 FFFFFFFF FFFFFFFF 00000000 FFFFFFFE
mulh_us      4 2 0 0 0 0 0 00000002 FFFFFFFF 00000000 FFFFFFFF
dot8_u       5 0 0 0 0 0 0 01020304 01010101 00000010 0000001A
dot8_s       5 3 0 0 0 0 0 FF02FE04 02020202 00000100 00000106
dot16_u      6 0 0 0 0 0 0 00020003 00040005 00000001 00000018
dot16_s      6 3 0 0 0 0 0 FFFF0002 00030004 00000000 00000005
clpx_re_s0   6 3 0 0 1 0 0 20004000 40004000 ABCD0000 ABCD1000
clpx_re_s1   6 3 0 0 1 0 1 20004000 40004000 ABCD0000 ABCD0800
clpx_im_s2   6 3 0 0 1 1 2 20004000 40004000 0000BEEF 0C00BEEF
clpx_im_s3   6 3 0 0 1 1 3 2000C000 40004000 00001234 FE001234

// ==== project.f ====
+incdir+include
verilog/mult_op_pkg.sv
verilog/mult_data_pkg.sv
verilog/mult_mulh_ctrl.sv
verilog/mult_short_datapath.sv
verilog/mult_dot_datapath.sv
verilog/mult_unit.sv
sim/mult_checker.sv
sim/tb_mult.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mult
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_mult.sv ====
// reads sim/mult_trace.txt from the run directory; test names up to 16 chars
`timescale 1ns/100ps

module tb_mult
  import mult_op_pkg::*;
  import mult_data_pkg::*;
;

  logic         clk;
  logic         rst_n;
  logic         req_valid;
  mult_req_t    req;
  logic         rsp_valid;
  mult_rsp_t    rsp;
  logic         busy;
  logic [127:0] cur_name;
  logic [31:0]  cur_exp;
  logic         cur_rnd;
  int           errors;
  int           chk_errors;
  int           pending;
  int           seed;
  bit           loaded;
  mult_req_t    req_list[$];
  logic [127:0] name_list[$];
  logic [31:0]  exp_list[$];
  bit           rnd_list[$];

  mult_unit i_mult_unit (
    .clk, .rst_n, .req_valid_i(req_valid), .req_i(req), .rsp_valid_o(rsp_valid),
    .rsp_o(rsp), .busy_o(busy)
  );

  mult_checker i_checker (
    .clk, .rst_n, .req_valid_i(req_valid), .req_i(req), .name_i(cur_name), .exp_i(cur_exp),
    .rnd_i(cur_rnd), .rsp_valid_i(rsp_valid), .rsp_i(rsp), .busy_i(busy),
    .errors_o(chk_errors), .pending_o(pending)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // trace and random stimulus
  ////////////////////////////////////////////////////////////////////////////

  // comment lines fail the field count and are skipped
  task automatic load_trace();
    int           fd;
    int           n;
    int           op_v;
    int           sg_v;
    int           hi_v;
    int           imm_v;
    int           cl_v;
    int           img_v;
    int           sh_v;
    logic [127:0] nm;
    logic [31:0]  a_v;
    logic [31:0]  b_v;
    logic [31:0]  c_v;
    logic [31:0]  e_v;
    string        line;
    mult_req_t    r;
    fd = $fopen("sim/mult_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open the trace file sim/mult_trace.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n = $sscanf(line, "%s %d %d %d %d %d %d %d %h %h %h %h", nm, op_v, sg_v, hi_v,
                    imm_v, cl_v, img_v, sh_v, a_v, b_v, c_v, e_v);
        if (n == 12) begin
          r            = '0;
          r.op         = mult_op_e'(op_v[2:0]);
          r.sign       = sg_v[1:0];
          r.subword_hi = hi_v[0];
          r.imm        = imm_v[4:0];
          r.is_clpx    = cl_v[0];
          r.clpx_img   = img_v[0];
          r.clpx_shift = sh_v[1:0];
          r.op_a       = mult_lanes_u'(a_v);
          r.op_b       = mult_lanes_u'(b_v);
          r.op_c       = mult_lanes_u'(c_v);
          req_list.push_back(r);
          name_list.push_back(nm);
          exp_list.push_back(e_v);
          rnd_list.push_back(1'b0);
        end
      end
      $fclose(fd);
    end
  endtask

  // expected value of these is worked out by the checker
  task automatic add_random_macs(input int count);
    mult_req_t r;
    for (int k = 0; k < count; k++) begin
      r      = '0;
      r.op   = MUL_MAC32;
      r.op_a = mult_lanes_u'($random(seed));
      r.op_b = mult_lanes_u'($random(seed));
      r.op_c = mult_lanes_u'($random(seed));
      req_list.push_back(r);
      name_list.push_back("rand_mac");
      exp_list.push_back('0);
      rnd_list.push_back(1'b1);
    end
  endtask

  // one-cycle strobe once the unit is idle
  task automatic drive_request(input int idx);
    @(posedge clk);
    #2;
    while (busy) begin
      @(posedge clk);
      #2;
    end
    req       = req_list[idx];
    cur_name  = name_list[idx];
    cur_exp   = exp_list[idx];
    cur_rnd   = rnd_list[idx];
    req_valid = 1'b1;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  // limit scales with the number of requests
  initial begin
    wait (loaded);
    repeat (req_list.size() * 8 + 20) @(posedge clk);
    $display("timeout, the unit stopped answering");
    $display("Errors found");
    $finish;
  end

  initial begin
    int total;
    req_valid = 1'b0;
    req       = '0;
    rst_n     = 1'b0;
    cur_name  = '0;
    cur_exp   = '0;
    cur_rnd   = 1'b0;
    errors    = 0;
    seed      = 32'hd3cb;
    load_trace();
    add_random_macs(4);
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    if (busy !== 1'b0 || rsp_valid !== 1'b0) begin
      $display("busy or response valid is not low after reset");
      errors++;
    end
    // checker flags any response in this gap
    repeat (3) @(posedge clk);
    for (int i = 0; i < req_list.size(); i++) begin
      drive_request(i);
    end
    while (busy) begin
      @(posedge clk);
      #2;
    end
    repeat (4) @(posedge clk);
    #2;
    if (pending > 0) begin
      $display("%0d requests got no response", pending);
    end
    total = errors + chk_errors + pending;
    $display("errors: %0d (testbench %0d, checker %0d, missing %0d)", total, errors,
             chk_errors, pending);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sim/mult_checker.sv ====
// assumes at most one request in flight; latency is 1 cycle, or 4 for MUL_H
`timescale 1ns/100ps

module mult_checker
  import mult_op_pkg::*;
  import mult_data_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         req_valid_i,
  input  mult_req_t    req_i,
  input  logic [127:0] name_i,
  input  logic [31:0]  exp_i,
  input  logic         rnd_i,
  input  logic         rsp_valid_i,
  input  mult_rsp_t    rsp_i,
  input  logic         busy_i,
  output int           errors_o,
  output int           pending_o
);

  logic [127:0] name_q[$];
  logic [31:0]  exp_q[$];
  int           due_q[$];
  int           cyc;

  initial begin
    errors_o  = 0;
    pending_o = 0;
    cyc       = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // in-order compare
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] e;
    cyc++;
    if (rst_n) begin
      // busy must hold while a result is still owed
      if (due_q.size() > 0 && cyc < due_q[0] && !busy_i) begin
        $display("busy dropped before the result of %0s", name_q[0]);
        errors_o++;
      end
      if (rsp_valid_i) begin
        if (due_q.size() == 0) begin
          $display("response %08h came with no request pending", rsp_i.data);
          errors_o++;
        end else begin
          if (rsp_i.data !== exp_q[0]) begin
            $display("Fail %0s expected %08h actual %08h", name_q[0], exp_q[0], rsp_i.data);
            errors_o++;
          end
          if (cyc != due_q[0]) begin
            $display("Fail %0s latency expected cycle %0d actual cycle %0d", name_q[0],
                     due_q[0], cyc);
            errors_o++;
          end
          void'(name_q.pop_front());
          void'(exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end
      if (req_valid_i) begin
        // random lines follow the mac rule c + a*b
        if (rnd_i) begin
          e = 32'(req_i.op_c) + 32'(req_i.op_a) * 32'(req_i.op_b);
        end else begin
          e = exp_i;
        end
        name_q.push_back(name_i);
        exp_q.push_back(e);
        // sampled one edge after the valid cycle starts
        due_q.push_back(cyc + ((req_i.op == MUL_H) ? 5 : 2));
      end
    end
    pending_o = due_q.size();
  end

endmodule

// ==== verilog/mult_unit.sv ====
// one request in flight, no back-pressure; a strobe while busy_o is high is illegal
`timescale 1ns/100ps
`include "mult_consts.svh"

module mult_unit
  import mult_op_pkg::*;
  import mult_data_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      req_valid_i,
  input  mult_req_t req_i,
  output logic      rsp_valid_o,
  output mult_rsp_t rsp_o,
  output logic      busy_o
);

  mult_req_t             req_q;
  logic                  valid_q;
  logic                  rsp_valid_q;
  logic                  busy_q;
  mult_rsp_t             rsp_q;
  logic                  mulh_start;
  logic                  mulh_active;
  logic [`MULT_SHW-1:0]  mulh_imm;
  logic [1:0]            mulh_sub;
  mult_sign_t            mulh_sign;
  logic                  mulh_arith;
  logic                  mulh_save;
  logic                  mulh_clear;
  logic                  mulh_done;
  logic                  single_done;
  mult_lanes_u           short_c;
  mult_rsp_t             short_rsp;
  mult_rsp_t             dot8_rsp;
  mult_rsp_t             dot16_rsp;
  mult_rsp_t             mac_rsp;
  mult_rsp_t             sel_rsp;
  logic [`MULT_XLEN-1:0] a_word;
  logic [`MULT_XLEN-1:0] b_word;
  logic [`MULT_XLEN-1:0] c_word;
  logic [`MULT_XLEN-1:0] mac_a;
  logic [`MULT_XLEN-1:0] mac_b;
  logic                  is_msu;

  // sequencer starts on the capture edge itself
  assign mulh_start = req_valid_i && (req_i.op == MUL_H);

  mult_mulh_ctrl i_mulh_ctrl (
    .clk, .rst_n, .start_i(mulh_start), .sign_i(req_q.sign), .active_o(mulh_active),
    .imm_o(mulh_imm), .subword_o(mulh_sub), .sign_o(mulh_sign), .shift_arith_o(mulh_arith),
    .save_o(mulh_save), .clearcarry_o(mulh_clear), .done_o(mulh_done)
  );

  // mulh accumulates through the result register
  assign short_c = mulh_active ? rsp_q.data : c_word;

  mult_short_datapath i_short (
    .clk, .rst_n, .op_i(req_q.op), .sign_i(req_q.sign), .subword_hi_i(req_q.subword_hi),
    .imm_i(req_q.imm), .op_a_i(req_q.op_a), .op_b_i(req_q.op_b), .op_c_i(short_c),
    .mulh_active_i(mulh_active), .mulh_imm_i(mulh_imm), .mulh_subword_i(mulh_sub),
    .mulh_sign_i(mulh_sign), .mulh_shift_arith_i(mulh_arith), .mulh_save_i(mulh_save),
    .mulh_clearcarry_i(mulh_clear), .result_o(short_rsp)
  );

  mult_dot_datapath i_dot (
    .sign_i(req_q.sign), .is_clpx_i(req_q.is_clpx), .clpx_img_i(req_q.clpx_img),
    .clpx_shift_i(req_q.clpx_shift), .op_a_i(req_q.op_a), .op_b_i(req_q.op_b),
    .op_c_i(req_q.op_c), .dot8_o(dot8_rsp), .dot16_o(dot16_rsp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // 32-bit mac and result select
  ////////////////////////////////////////////////////////////////////////////

  assign a_word = req_q.op_a;
  assign b_word = req_q.op_b;
  assign c_word = req_q.op_c;

  // msu: c + ~a*b + b, which is c - a*b
  assign is_msu       = (req_q.op == MUL_MSU32);
  assign mac_a        = a_word ^ {`MULT_XLEN{is_msu}};
  assign mac_b        = b_word & {`MULT_XLEN{is_msu}};
  assign mac_rsp.data = c_word + mac_b + mac_a * b_word;

  always_comb begin
    case (req_q.op)
      MUL_MAC32, MUL_MSU32: sel_rsp = mac_rsp;
      MUL_I, MUL_IR, MUL_H: sel_rsp = short_rsp;
      MUL_DOT8:             sel_rsp = dot8_rsp;
      MUL_DOT16:            sel_rsp = dot16_rsp;
      default:              sel_rsp = '0;
    endcase
  end

  // single-cycle ops finish one cycle after capture
  assign single_done = valid_q && (req_q.op != MUL_H);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
      busy_q      <= 1'b0;
    end else begin
      valid_q     <= req_valid_i;
      rsp_valid_q <= single_done || mulh_done;
      if (req_valid_i) begin
        busy_q <= 1'b1;
      end else if (single_done || mulh_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      req_q <= req_i;
    end
  end

  // cleared for mulh, then one partial sum per step, last one is the result
  always_ff @(posedge clk) begin
    if (mulh_active) begin
      rsp_q <= short_rsp;
    end else if (mulh_start) begin
      rsp_q <= '0;
    end else if (single_done) begin
      rsp_q <= sel_rsp;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign busy_o      = busy_q;

  // source must wait for busy_o to drop
  no_strobe_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid_i |-> !busy_o);

  // signed mulh ends as the upper word of the 64-bit product
  mulh_signed_a: assert property (@(posedge clk) disable iff (!rst_n)
    (mulh_done && (req_q.op == MUL_H) && (req_q.sign == 2'b11)) |=>
    (rsp_o.data == 32'((64'($signed(a_word)) * 64'($signed(b_word))) >>> 32)));

endmodule

// ==== verilog/mult_dot_datapath.sv ====
// purely combinational; complex mode is only meaningful with the DOT16 result
`timescale 1ns/100ps
`include "mult_consts.svh"

module mult_dot_datapath
  import mult_op_pkg::*;
  import mult_data_pkg::*;
(
  input  mult_sign_t  sign_i,
  input  logic        is_clpx_i,
  input  logic        clpx_img_i,
  input  logic [1:0]  clpx_shift_i,
  input  mult_lanes_u op_a_i,
  input  mult_lanes_u op_b_i,
  input  mult_lanes_u op_c_i,
  output mult_rsp_t   dot8_o,
  output mult_rsp_t   dot16_o
);

  logic [3:0][`MULT_BLEN:0]       byte_a;
  logic [3:0][`MULT_BLEN:0]       byte_b;
  logic [3:0][2*`MULT_BLEN+1:0]   byte_prod;
  logic [1:0][`MULT_HLEN:0]       half_a;
  logic [1:0][`MULT_HLEN:0]       half_b;
  logic [`MULT_HLEN:0]            half_a1_neg;
  logic [1:0][2*`MULT_HLEN+1:0]   half_prod;
  logic [`MULT_XLEN-1:0]          dot8_sum;
  logic [`MULT_XLEN-1:0]          half_acc;
  logic [`MULT_XLEN-1:0]          dot16_sum;
  logic [`MULT_HLEN:0]            clpx_part;
  logic [`MULT_HLEN:0]            clpx_shifted;
  logic                           swap_b;
  logic                           neg_hi;

  ////////////////////////////////////////////////////////////////////////////
  // byte lanes
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < 4; k++) begin : g_byte
    assign byte_a[k] = {sign_i[0] & op_a_i.octet[k][`MULT_BLEN-1], op_a_i.octet[k]};
    assign byte_b[k] = {sign_i[1] & op_b_i.octet[k][`MULT_BLEN-1], op_b_i.octet[k]};
    assign byte_prod[k] = $signed(byte_a[k]) * $signed(byte_b[k]);
  end

  // c plus four sign extended byte products
  always_comb begin
    dot8_sum = op_c_i;
    for (int k = 0; k < 4; k++) begin
      dot8_sum = dot8_sum + `MULT_XLEN'($signed(byte_prod[k]));
    end
  end
  assign dot8_o.data = dot8_sum;

  ////////////////////////////////////////////////////////////////////////////
  // half lanes and complex
  ////////////////////////////////////////////////////////////////////////////

  // imag crosses b halves, real negates the high product
  assign swap_b = is_clpx_i & clpx_img_i;
  assign neg_hi = is_clpx_i & ~clpx_img_i;

  for (genvar k = 0; k < 2; k++) begin : g_half
    assign half_a[k] = {sign_i[0] & op_a_i.half[k][`MULT_HLEN-1], op_a_i.half[k]};
    assign half_b[k] = {sign_i[1] & op_b_i.half[k ^ int'(swap_b)][`MULT_HLEN-1],
                        op_b_i.half[k ^ int'(swap_b)]};
  end

  // -ah*bh as ~ah*bh plus bh, the bh goes in through the accumulator
  assign half_a1_neg = half_a[1] ^ {(`MULT_HLEN+1){neg_hi}};

  assign half_prod[0] = $signed(half_a[0]) * $signed(half_b[0]);
  assign half_prod[1] = $signed(half_a1_neg) * $signed(half_b[1]);

  // complex ignores c in the sum
  assign half_acc = is_clpx_i ? (`MULT_XLEN'($signed(half_b[1])) & {`MULT_XLEN{~clpx_img_i}})
                              : op_c_i;

  assign dot16_sum = half_prod[0][`MULT_XLEN-1:0] + half_prod[1][`MULT_XLEN-1:0] + half_acc;

  // q15 style part, bits 31..15 then the post shift
  assign clpx_part    = dot16_sum[`MULT_XLEN-1:`MULT_HLEN-1];
  assign clpx_shifted = $signed(clpx_part) >>> clpx_shift_i;

  // the untouched half comes from c
  always_comb begin
    if (!is_clpx_i) begin
      dot16_o.data = dot16_sum;
    end else if (clpx_img_i) begin
      dot16_o.data = {clpx_shifted[`MULT_HLEN-1:0], op_c_i.half[0]};
    end else begin
      dot16_o.data = {op_c_i.half[1], clpx_shifted[`MULT_HLEN-1:0]};
    end
  end

endmodule

// ==== verilog/mult_short_datapath.sv ====
// combinational result; op_c_i must carry the running partial sum while mulh is active
`timescale 1ns/100ps
`include "mult_consts.svh"

module mult_short_datapath
  import mult_op_pkg::*;
  import mult_data_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  mult_op_e             op_i,
  input  mult_sign_t           sign_i,
  input  logic                 subword_hi_i,
  input  logic [`MULT_SHW-1:0] imm_i,
  input  mult_lanes_u          op_a_i,
  input  mult_lanes_u          op_b_i,
  input  mult_lanes_u          op_c_i,
  // overrides from the mulh sequencer
  input  logic                 mulh_active_i,
  input  logic [`MULT_SHW-1:0] mulh_imm_i,
  input  logic [1:0]           mulh_subword_i,
  input  mult_sign_t           mulh_sign_i,
  input  logic                 mulh_shift_arith_i,
  input  logic                 mulh_save_i,
  input  logic                 mulh_clearcarry_i,
  output mult_rsp_t            result_o
);

  logic [`MULT_SHW-1:0]    sel_imm;
  logic [1:0]              sel_sub;
  mult_sign_t              sel_sign;
  logic                    sel_arith;
  logic [`MULT_HLEN:0]     ext_a;
  logic [`MULT_HLEN:0]     ext_b;
  logic [`MULT_XLEN-1:0]   c_word;
  logic [`MULT_XLEN:0]     ext_c;
  logic [`MULT_XLEN-1:0]   round_one;
  logic [`MULT_XLEN-1:0]   round_val;
  logic [2*`MULT_HLEN+1:0] fresh_prod;
  logic [2*`MULT_HLEN+1:0] prod;
  logic [2*`MULT_HLEN+1:0] mac;
  logic [2*`MULT_HLEN+1:0] shifted;
  logic                    msb1;
  logic                    msb0;
  logic                    carry_q;
  logic [`MULT_HLEN:0]     last_a_q;
  logic [`MULT_HLEN:0]     last_b_q;
  logic [2*`MULT_HLEN+1:0] last_prod_q;
  logic                    reuse;
  logic                    path_used;

  // mulh fields win while the sequencer runs
  assign sel_imm   = mulh_active_i ? mulh_imm_i : imm_i;
  assign sel_sub   = mulh_active_i ? mulh_subword_i : {2{subword_hi_i}};
  assign sel_sign  = mulh_active_i ? mulh_sign_i : sign_i;
  assign sel_arith = mulh_active_i ? mulh_shift_arith_i : sign_i[0];

  // half select, then extend to 17 bits by signedness
  assign ext_a = {sel_sign[0] & op_a_i.half[sel_sub[0]][`MULT_HLEN-1], op_a_i.half[sel_sub[0]]};
  assign ext_b = {sel_sign[1] & op_b_i.half[sel_sub[1]][`MULT_HLEN-1], op_b_i.half[sel_sub[1]]};

  // mulh puts the saved carry on top of c
  assign c_word = op_c_i;
  assign ext_c  = mulh_active_i ? {carry_q, c_word} : {c_word[`MULT_XLEN-1], c_word};

  // round by half an lsb of the shifted result
  assign round_one = `MULT_XLEN'(1) << imm_i;
  assign round_val = (op_i == MUL_IR) ? {1'b0, round_one[`MULT_XLEN-1:1]} : '0;

  ////////////////////////////////////////////////////////////////////////////
  // product with reuse of the last one
  ////////////////////////////////////////////////////////////////////////////

  assign reuse      = (ext_a == last_a_q) && (ext_b == last_b_q);
  assign fresh_prod = $signed(ext_a) * $signed(ext_b);
  assign prod       = reuse ? last_prod_q : fresh_prod;

  // 34-bit sum, c sign extended once more
  assign mac = {ext_c[`MULT_XLEN], ext_c} + prod + {2'b00, round_val};

  // mulh keeps both bits above the word, plain ops repeat bit 31
  assign msb1 = mulh_active_i ? mac[2*`MULT_HLEN+1] : mac[`MULT_XLEN-1];
  assign msb0 = mulh_active_i ? mac[`MULT_XLEN] : mac[`MULT_XLEN-1];

  assign shifted = $signed({sel_arith & msb1, sel_arith & msb0, mac[`MULT_XLEN-1:0]})
                   >>> sel_imm;
  assign result_o.data = shifted[`MULT_XLEN-1:0];

  // only refresh when this path is actually in use
  assign path_used = mulh_active_i || (op_i == MUL_I) || (op_i == MUL_IR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_a_q    <= '0;
      last_b_q    <= '0;
      last_prod_q <= '0;
    end else if (path_used && !reuse) begin
      last_a_q    <= ext_a;
      last_b_q    <= ext_b;
      last_prod_q <= fresh_prod;
    end
  end

  // carry out of bit 32 between mulh steps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      carry_q <= 1'b0;
    end else if (mulh_save_i) begin
      carry_q <= ~mulh_clearcarry_i & mac[`MULT_XLEN];
    end else if (!mulh_active_i) begin
      carry_q <= 1'b0;
    end
  end

endmodule

// ==== verilog/mult_mulh_ctrl.sv ====
// leaves FINISH after one cycle by itself; start_i is only honoured in IDLE_MULT
`timescale 1ns/100ps
`include "mult_consts.svh"

module mult_mulh_ctrl
  import mult_op_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  mult_sign_t           sign_i,
  output logic                 active_o,
  output logic [`MULT_SHW-1:0] imm_o,
  output logic [1:0]           subword_o,
  output mult_sign_t           sign_o,
  output logic                 shift_arith_o,
  output logic                 save_o,
  output logic                 clearcarry_o,
  output logic                 done_o
);

  mulh_state_e state_q;
  mulh_state_e state_d;

  ////////////////////////////////////////////////////////////////////////////
  // step decode
  ////////////////////////////////////////////////////////////////////////////

  // subword_o bit 0 picks the half of a, bit 1 the half of b
  always_comb begin
    state_d       = state_q;
    active_o      = 1'b1;
    imm_o         = '0;
    subword_o     = 2'b00;
    sign_o        = 2'b00;
    shift_arith_o = 1'b0;
    save_o        = 1'b0;
    clearcarry_o  = 1'b0;
    done_o        = 1'b0;
    case (state_q)
      IDLE_MULT: begin
        // subword path runs on the request fields
        active_o = 1'b0;
        if (start_i) begin
          state_d = STEP0;
        end
      end
      STEP0: begin
        // al*bl, unsigned and never beyond 32 bits
        // only its upper half matters further on
        imm_o   = `MULT_SHW'(`MULT_HLEN);
        state_d = STEP1;
      end
      STEP1: begin
        // al*bh, signed only through b
        // 33-bit sum, bit 32 kept as carry
        sign_o        = {sign_i[1], 1'b0};
        subword_o     = 2'b10;
        shift_arith_o = 1'b1;
        save_o        = 1'b1;
        state_d       = STEP2;
      end
      STEP2: begin
        // ah*bl, signed only through a
        // bits above 32 are shifted back in, so the carry goes
        sign_o        = {1'b0, sign_i[0]};
        subword_o     = 2'b01;
        imm_o         = `MULT_SHW'(`MULT_HLEN);
        shift_arith_o = 1'b1;
        save_o        = 1'b1;
        clearcarry_o  = 1'b1;
        state_d       = FINISH;
      end
      FINISH: begin
        // ah*bh with the request signedness
        sign_o    = sign_i;
        subword_o = 2'b11;
        done_o    = 1'b1;
        state_d   = IDLE_MULT;
      end
      default: begin
        state_d = IDLE_MULT;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE_MULT;
    end else begin
      state_q <= state_d;
    end
  end

  // only the five named encodings may ever be held
  state_legal_a: assert property (@(posedge clk) disable iff (!rst_n)
    state_q inside {IDLE_MULT, STEP0, STEP1, STEP2, FINISH});

endmodule

// ==== verilog/mult_data_pkg.sv ====
// operand words are always 32 bits; the lane views overlay the same bits
`include "mult_consts.svh"

package mult_data_pkg;
  import mult_op_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // operand lanes
  ////////////////////////////////////////////////////////////////////////////

  // one operand word, read as halves or as bytes
  // half[0] and octet[0] are the least significant lanes
  typedef union packed {
    logic [1:0][`MULT_HLEN-1:0] half;
    logic [3:0][`MULT_BLEN-1:0] octet;
  } mult_lanes_u;

  ////////////////////////////////////////////////////////////////////////////
  // request and response
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    mult_op_e             op;
    mult_sign_t           sign;
    // upper halves for MUL_I and MUL_IR
    logic                 subword_hi;
    // shift amount for the subword path
    logic [`MULT_SHW-1:0] imm;
    // complex mode of DOT16
    logic                 is_clpx;
    logic                 clpx_img;
    logic [1:0]           clpx_shift;
    mult_lanes_u          op_a;
    mult_lanes_u          op_b;
    // accumulator operand
    mult_lanes_u          op_c;
  } mult_req_t;

  typedef struct packed {
    logic [`MULT_XLEN-1:0] data;
  } mult_rsp_t;

endpackage

// ==== verilog/mult_op_pkg.sv ====
// encodings are shared with the trace file, so the op values must not be reordered
package mult_op_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // operations
  ////////////////////////////////////////////////////////////////////////////

  // MUL_H is the only multi-cycle op
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'd0,
    MUL_MSU32 = 3'd1,
    MUL_I     = 3'd2,
    MUL_IR    = 3'd3,
    MUL_H     = 3'd4,
    MUL_DOT8  = 3'd5,
    MUL_DOT16 = 3'd6
  } mult_op_e;

  // mulh sequencer, one partial product per state
  typedef enum logic [2:0] {
    IDLE_MULT = 3'd0,
    STEP0     = 3'd1,
    STEP1     = 3'd2,
    STEP2     = 3'd3,
    FINISH    = 3'd4
  } mulh_state_e;

  // bit 0 for operand a, bit 1 for operand b
  typedef logic [1:0] mult_sign_t;

endpackage

// ==== include/mult_consts.svh ====
// fixed 32-bit word; the datapaths assume a half is two bytes and a word is two halves
`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// full operand and result width
`define MULT_XLEN 32

// subword lane widths
`define MULT_HLEN 16
`define MULT_BLEN 8

// width of a shift amount, enough for 0..31
`define MULT_SHW 5

`endif
